//--- bench/replay_asserts.sv
module replay_asserts
    import replay_pkg::*;
(
    input logic   clk,
    input logic   arst_n,
    input logic   mem_req,
    input logic   mem_busy,
    input logic   out_valid,
    input entry_t out_data,
    input logic   out_ready,
    input logic   soft_rst,
    input logic   busy
);

    timeunit 1ns;
    timeprecision 100ps;

    // Requests only while the memory can take them
    req_when_free: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |-> !mem_busy)
        else $error("mem_req high while mem_busy high");

    // Held output under back-pressure, soft reset may drop it
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready && !soft_rst) |=> (out_valid && $stable(out_data)))
        else $error("out_valid or out_data changed while stalled");

    // Idle coming out of reset
    idle_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !busy)
        else $error("busy high after reset");

endmodule

bind replay_top replay_asserts i_replay_asserts (
    .clk, .arst_n, .mem_req, .mem_busy, .out_valid, .out_data, .out_ready,
    .soft_rst, .busy
);

//--- bench/replay_tb.sv
`include "replay_config.svh"

module replay_tb
    import replay_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NQ        = `REPLAY_NUM_QUEUES;
    localparam int RUN_WORDS = 2 + 4 * NQ;
    localparam int TIMEOUT   = 20000;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        mem_req;
    mem_addr_t   mem_addr;
    logic        mem_busy;
    mem_rsp_t    mem_rsp;
    logic        out_valid;
    entry_t      out_data;
    logic        out_ready;

    integer      seed;
    int          errors;
    int          received;
    int          checked;
    int          stall;
    int          cycle;
    logic        beat_k;
    logic [31:0] tests [256];
    queue_cfg_t  cfg [NQ];
    entry_t      expected [$];
    mem_addr_t   pend_addr [$];
    int          pend_due [$];

    replay_top i_replay_top (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .mem_req, .mem_addr, .mem_busy, .mem_rsp,
        .out_valid, .out_data, .out_ready
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Word k of address a holds 2a + k
    function automatic beat_t beat_value(input mem_addr_t a, input logic k);
        return 2 * beat_t'(a) + beat_t'(k);
    endfunction

    // Round robin over the configured queues with one word per visit
    function automatic void build_expected();
        mem_addr_t addr [NQ];
        count_t    cnt [NQ];
        logic      work;
        expected.delete();
        for (int q = 0; q < NQ; q++) begin
            addr[q] = cfg[q].low;
            cnt[q]  = cfg[q].count;
        end
        work = 1'b1;
        while (work) begin
            work = 1'b0;
            for (int q = 0; q < NQ; q++) begin
                if (cfg[q].enable && cnt[q] != '0) begin
                    work = 1'b1;
                    expected.push_back({beat_value(addr[q], 1'b1), beat_value(addr[q], 1'b0)});
                    if (mem_addr_t'(addr[q] + 1) == cfg[q].high) begin
                        addr[q] = cfg[q].low;
                        cnt[q]  = cnt[q] - 1;
                    end else begin
                        addr[q] = addr[q] + 1;
                    end
                end
            end
        end
    endfunction

    // Memory model with random stalls, in-order bursts and 2 to 5 cycles of latency
    initial begin
        int r;
        forever begin
            @(negedge clk);
            cycle++;
            r = $random(seed);
            mem_busy <= (r[1:0] == 2'b00);
            mem_rsp  <= '0;
            // Occasional gap so the two beats are not always adjacent
            if (pend_addr.size() > 0 && cycle >= pend_due[0] && r[4:2] != 3'b000) begin
                mem_rsp.rvalid <= 1'b1;
                mem_rsp.rdata  <= beat_value(pend_addr[0], beat_k);
                if (beat_k) begin
                    void'(pend_addr.pop_front());
                    void'(pend_due.pop_front());
                end
                beat_k = !beat_k;
            end
            #1;
            if (mem_req && !mem_busy) begin
                pend_addr.push_back(mem_addr);
                pend_due.push_back(cycle + 2 + int'(r[6:5]));
            end
        end
    end

    // Output sink with random back-pressure and in-order compare
    initial begin
        int     r;
        entry_t exp_e;
        forever begin
            @(negedge clk);
            r = $random(seed);
            out_ready <= ($unsigned(r) % 100) >= stall;
            #1;
            if (out_valid && out_ready) begin
                received++;
                checked++;
                if (expected.size() == 0) begin
                    $display("Unexpected entry 0x%016h on the output stream", out_data);
                    errors++;
                end else begin
                    exp_e = expected.pop_front();
                    if (out_data !== exp_e) begin
                        $display("Error: out_data expected 0x%016h got 0x%016h", exp_e, out_data);
                        errors++;
                    end
                end
            end
        end
    end

    // One setup and one access cycle with no wait states
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(negedge clk);
        penable <= 1'b1;
        @(negedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(negedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(negedge clk);
        penable <= 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        if (pready !== 1'b1) begin
            $display("Error: pready expected 0x1 got 0x%01h", pready);
            errors++;
        end
        @(negedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s expected 0x%08h got 0x%08h", name, exp, got);
            errors++;
        end
    endtask

    task automatic write_check(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_write(addr, data);
        apb_read(addr, rd, err);
        check_reg($sformatf("prdata[0x%02h]", addr), rd, data);
        check_reg($sformatf("pslverr[0x%02h]", addr), 32'(err), 32'h0);
    endtask

    task automatic wait_received(input int target);
        int timer;
        timer = 0;
        while (received < target && timer < TIMEOUT) begin
            @(negedge clk);
            timer++;
        end
        if (received < target) begin
            $display("Timeout with %0d of %0d entries received", received, target);
            errors++;
        end
    endtask

    // Stale bursts of an aborted run must drain first
    task automatic wait_memory_idle();
        int timer;
        timer = 0;
        while (pend_addr.size() > 0 && timer < TIMEOUT) begin
            @(negedge clk);
            timer++;
        end
        if (pend_addr.size() > 0) begin
            $display("Timeout while memory still had %0d reads pending", pend_addr.size());
            errors++;
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic run_test(input int base);
        int          abort_at;
        int          total;
        logic [7:0]  qbase;
        logic [31:0] rd;
        logic        err;
        stall    = tests[base];
        abort_at = tests[base + 1];
        for (int q = 0; q < NQ; q++) begin
            cfg[q].enable = tests[base + 2 + 4 * q][0];
            cfg[q].low    = mem_addr_t'(tests[base + 3 + 4 * q]);
            cfg[q].high   = mem_addr_t'(tests[base + 4 + 4 * q]);
            cfg[q].count  = count_t'(tests[base + 5 + 4 * q]);
            qbase = 8'(q) * `REPLAY_REG_Q_STRIDE;
            write_check(qbase + `REPLAY_REG_Q_EN, 32'(cfg[q].enable));
            write_check(qbase + `REPLAY_REG_Q_LOW, 32'(cfg[q].low));
            write_check(qbase + `REPLAY_REG_Q_HIGH, 32'(cfg[q].high));
            write_check(qbase + `REPLAY_REG_Q_COUNT, 32'(cfg[q].count));
        end
        build_expected();
        total    = expected.size();
        received = 0;
        apb_write(`REPLAY_REG_CTRL, 32'h1);
        apb_read(`REPLAY_REG_STATUS, rd, err);
        check_reg("STATUS busy during run", rd, 32'h1);
        if (abort_at != 0) begin
            wait_received(abort_at);
            apb_write(`REPLAY_REG_CTRL, 32'h2);
            expected.delete();
            repeat (4) @(negedge clk);
            if (out_valid) begin
                $display("Output stream still valid after soft reset");
                errors++;
            end
            wait_memory_idle();
            // Fresh start replays from the top of every window
            build_expected();
            received = 0;
            apb_write(`REPLAY_REG_CTRL, 32'h1);
        end
        wait_received(total);
        repeat (20) @(negedge clk);
        if (expected.size() != 0) begin
            $display("Run at word %0d ended with %0d entries missing", base, expected.size());
            errors++;
        end
        apb_read(`REPLAY_REG_STATUS, rd, err);
        check_reg("STATUS busy after run", rd, 32'h0);
        apb_read(`REPLAY_REG_SENT, rd, err);
        check_reg("SENT", rd, 32'(received));
    endtask

    initial begin
        int          runs;
        logic [31:0] rd;
        logic        err;
        seed      = 32'h1778d550;
        errors    = 0;
        received  = 0;
        checked   = 0;
        stall     = 0;
        cycle     = 0;
        beat_k    = 1'b0;
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        mem_busy  = 1'b0;
        mem_rsp   = '0;
        out_ready = 1'b0;
        $readmemh("bench/replay_tests.txt", tests);
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        // Unmapped offsets answer with an error
        apb_read(8'h4C, rd, err);
        check_reg("pslverr[0x4c]", 32'(err), 32'h1);
        apb_read(8'h06, rd, err);
        check_reg("pslverr[0x06]", 32'(err), 32'h1);
        apb_read(`REPLAY_REG_STATUS, rd, err);
        check_reg("STATUS after reset", rd, 32'h0);

        runs = tests[0];
        if (runs <= 0) begin
            $display("No test vectors were read from the data file");
            errors++;
        end
        for (int r = 0; r < runs; r++) begin
            run_test(1 + r * RUN_WORDS);
        end

        $display("Summary: %0d runs, %0d entries checked, %0d errors", runs, checked, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- bench/replay_tests.txt
// Replay test vectors, all values hex, first word is the number of runs
// Per run: stall_pct abort_after, then per queue 0..3: enable low high count
// stall_pct is the percent of cycles with out_ready low
// abort_after above zero soft resets after that many entries, then replays in full
5
// Single queue, window of four words, two passes
00 00  1 0010 0014 0002  0 0000 0000 0000  0 0000 0000 0000  0 0000 0000 0000
// Three queues interleaved, queue 1 disabled
00 00  1 0020 0023 0001  0 0030 0038 0005  1 0040 0042 0003  1 0100 0105 0002
// Same traffic with out_ready low 70 percent of the time
46 00  1 0020 0023 0001  0 0030 0038 0005  1 0040 0042 0003  1 0100 0105 0002
// Soft reset after five entries, then a full replay
1E 05  1 0020 0023 0001  0 0030 0038 0005  1 0040 0042 0003  1 0100 0105 0002
// One-word window next to a short queue
32 00  0 0000 0000 0000  1 0300 0304 0001  0 0000 0000 0000  1 0200 0201 0004

//--- rtl/mem_to_fifo.sv
`include "replay_config.svh"

module mem_to_fifo
    import replay_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  queue_cfg_t qcfg [`REPLAY_NUM_QUEUES],
    input  logic       start,
    input  logic       soft_rst,
    output logic       mem_req,
    output mem_addr_t  mem_addr,
    input  logic       mem_busy,
    input  mem_rsp_t   mem_rsp,
    output logic       fifo_wr,
    output entry_t     fifo_din,
    input  level_t     level,
    output logic       busy
);

    sched_state_t            state;
    qid_t                    ptr;
    mem_addr_t               cur_addr  [`REPLAY_NUM_QUEUES];
    count_t                  cur_count [`REPLAY_NUM_QUEUES];
    level_t                  credits;
    level_t                  credits_nxt;
    level_t                  drop_cnt;
    logic                    phase;
    beat_t                   low_beat;
    logic                    eligible;
    logic                    any_work;
    logic                    credit_ok;
    logic                    issue;
    logic                    pair_done;
    logic [$bits(level_t):0] demand;

    // Run ends once no enabled queue has passes left
    always_comb begin
        any_work = 1'b0;
        for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
            if (qcfg[q].enable && (cur_count[q] != '0)) begin
                any_work = 1'b1;
            end
        end
    end

    assign eligible  = qcfg[ptr].enable && (cur_count[ptr] != '0);

    // Stored entries, reads in flight and the entry being written
    assign demand    = {1'b0, level} + {1'b0, credits} + fifo_wr;
    assign credit_ok = demand < `REPLAY_FIFO_DEPTH;

    // Request only when the memory can take it this cycle
    assign issue     = (state == RUN) && eligible && !mem_busy && credit_ok;
    assign mem_req   = issue;
    assign mem_addr  = cur_addr[ptr];

    // Second beat of a burst
    assign pair_done = mem_rsp.rvalid && phase;

    always_comb begin
        credits_nxt = credits;
        if (issue && !pair_done) begin
            credits_nxt = credits + 1'b1;
        end else if (!issue && pair_done) begin
            credits_nxt = credits - 1'b1;
        end
    end

    // Round-robin scheduler with per-queue address and count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            ptr   <= '0;
            for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
                cur_addr[q]  <= '0;
                cur_count[q] <= '0;
            end
        end else if (soft_rst) begin
            state <= IDLE;
            ptr   <= '0;
            for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
                cur_addr[q]  <= '0;
                cur_count[q] <= '0;
            end
        end else if (start) begin
            // Reload every window from the top
            state <= RUN;
            ptr   <= '0;
            for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
                cur_addr[q]  <= qcfg[q].low;
                cur_count[q] <= qcfg[q].count;
            end
        end else if (state == RUN) begin
            if (!any_work) begin
                state <= IDLE;
            end else if (!eligible) begin
                // Nothing to do here, try the next queue
                ptr <= ptr + 1'b1;
            end else if (issue) begin
                ptr <= ptr + 1'b1;
                // Last word of the window, wrap and spend one pass
                if (cur_addr[ptr] == qcfg[ptr].high - 1'b1) begin
                    cur_addr[ptr]  <= qcfg[ptr].low;
                    cur_count[ptr] <= cur_count[ptr] - 1'b1;
                end else begin
                    cur_addr[ptr] <= cur_addr[ptr] + 1'b1;
                end
            end
        end
    end

    // Credits, drop tracking and write strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits  <= '0;
            drop_cnt <= '0;
            phase    <= 1'b0;
            fifo_wr  <= 1'b0;
        end else begin
            credits <= credits_nxt;
            // Beat pairing survives soft reset so stale bursts stay aligned
            if (mem_rsp.rvalid) begin
                phase <= !phase;
            end
            if (soft_rst) begin
                // Everything still in flight belongs to the aborted run
                drop_cnt <= credits_nxt;
                fifo_wr  <= 1'b0;
            end else begin
                fifo_wr <= pair_done && (drop_cnt == '0);
                if (pair_done && (drop_cnt != '0)) begin
                    drop_cnt <= drop_cnt - 1'b1;
                end
            end
        end
    end

    // Two-beat packer
    always_ff @(posedge clk) begin
        if (mem_rsp.rvalid && !phase) begin
            low_beat <= mem_rsp.rdata;
        end
        if (pair_done) begin
            fifo_din <= {mem_rsp.rdata, low_beat};
        end
    end

    // Live reads are those beyond the ones being dropped
    assign busy = (state == RUN) || (credits != drop_cnt) || fifo_wr;

endmodule

//--- rtl/replay_config.svh
`ifndef REPLAY_CONFIG_SVH
`define REPLAY_CONFIG_SVH

// Queue count and datapath widths
`define REPLAY_NUM_QUEUES   4
`define REPLAY_ADDR_W       16
`define REPLAY_BEAT_W       32
`define REPLAY_COUNT_W      16

// Buffer entries, one per two-beat burst
`define REPLAY_FIFO_DEPTH   8

// Global registers
`define REPLAY_REG_CTRL     8'h40
`define REPLAY_REG_STATUS   8'h44
`define REPLAY_REG_SENT     8'h48

// Per-queue block at stride times queue number
`define REPLAY_REG_Q_STRIDE 8'h10
`define REPLAY_REG_Q_EN     4'h0
`define REPLAY_REG_Q_LOW    4'h4
`define REPLAY_REG_Q_HIGH   4'h8
`define REPLAY_REG_Q_COUNT  4'hC

`endif

//--- rtl/replay_fifo.sv
`include "replay_config.svh"

module replay_fifo
    import replay_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   soft_rst,
    input  logic   wr,
    input  entry_t din,
    input  logic   rd,
    output entry_t dout,
    output logic   empty,
    output level_t level
);

    localparam int PTR_W = $clog2(`REPLAY_FIFO_DEPTH);

    entry_t           mem [`REPLAY_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign empty = (level == '0);
    assign do_rd = rd && !empty;
    assign do_wr = wr && (level != level_t'(`REPLAY_FIFO_DEPTH));

    // Fall-through head
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // Power-of-two depth, pointers wrap on their own
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else if (soft_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                level <= level + 1'b1;
            end else if (!do_wr && do_rd) begin
                level <= level - 1'b1;
            end
        end
    end

endmodule

//--- rtl/replay_pkg.sv
`include "replay_config.svh"

package replay_pkg;

    // Word address into the replay memory
    typedef logic [`REPLAY_ADDR_W-1:0] mem_addr_t;

    // One memory beat
    typedef logic [`REPLAY_BEAT_W-1:0] beat_t;

    // Packed burst, first beat in the low half
    typedef logic [2*`REPLAY_BEAT_W-1:0] entry_t;

    // Remaining passes over a window
    typedef logic [`REPLAY_COUNT_W-1:0] count_t;

    // Queue number
    typedef logic [$clog2(`REPLAY_NUM_QUEUES)-1:0] qid_t;

    // Fill level, wide enough to hold a full FIFO
    typedef logic [$clog2(`REPLAY_FIFO_DEPTH+1)-1:0] level_t;

    // Software view of one queue
    typedef struct packed {
        logic      enable;
        mem_addr_t low;
        mem_addr_t high;
        count_t    count;
    } queue_cfg_t;

    // Read data beat from memory
    typedef struct packed {
        logic  rvalid;
        beat_t rdata;
    } mem_rsp_t;

    typedef enum logic {IDLE, RUN} sched_state_t;

endpackage

//--- rtl/replay_regs.sv
`include "replay_config.svh"

module replay_regs
    import replay_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output queue_cfg_t  qcfg [`REPLAY_NUM_QUEUES],
    output logic        start,
    output logic        soft_rst,
    input  logic        busy,
    input  logic [31:0] sent_count
);

    logic       access;
    logic       wr_en;
    logic       in_queues;
    logic       addr_hit;
    qid_t       q_sel;
    logic [3:0] field;

    // Access phase is always a single cycle
    assign pready    = 1'b1;
    assign access    = psel && penable;
    assign wr_en     = access && pwrite;

    // Queue blocks sit below the global registers
    assign in_queues = paddr < `REPLAY_REG_CTRL;
    assign q_sel     = qid_t'(paddr / `REPLAY_REG_Q_STRIDE);
    assign field     = paddr[3:0];

    // Control pulses straight from the access cycle
    assign start     = wr_en && (paddr == `REPLAY_REG_CTRL) && pwdata[0];
    assign soft_rst  = wr_en && (paddr == `REPLAY_REG_CTRL) && pwdata[1];

    assign pslverr   = access && !addr_hit;

    // Read mux and address decode
    always_comb begin
        addr_hit = 1'b0;
        prdata   = '0;
        if (in_queues) begin
            case (field)
                `REPLAY_REG_Q_EN: begin
                    addr_hit = 1'b1;
                    prdata   = 32'(qcfg[q_sel].enable);
                end
                `REPLAY_REG_Q_LOW: begin
                    addr_hit = 1'b1;
                    prdata   = 32'(qcfg[q_sel].low);
                end
                `REPLAY_REG_Q_HIGH: begin
                    addr_hit = 1'b1;
                    prdata   = 32'(qcfg[q_sel].high);
                end
                `REPLAY_REG_Q_COUNT: begin
                    addr_hit = 1'b1;
                    prdata   = 32'(qcfg[q_sel].count);
                end
                default: ;
            endcase
        end else begin
            case (paddr)
                // Pulse bits only, reads as zero
                `REPLAY_REG_CTRL: addr_hit = 1'b1;
                `REPLAY_REG_STATUS: begin
                    addr_hit = 1'b1;
                    prdata   = 32'(busy);
                end
                `REPLAY_REG_SENT: begin
                    addr_hit = 1'b1;
                    prdata   = sent_count;
                end
                default: ;
            endcase
        end
    end

    // Queue configuration, written at the end of the access cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
                qcfg[q] <= '0;
            end
        end else if (wr_en && in_queues) begin
            case (field)
                `REPLAY_REG_Q_EN:    qcfg[q_sel].enable <= pwdata[0];
                `REPLAY_REG_Q_LOW:   qcfg[q_sel].low    <= mem_addr_t'(pwdata);
                `REPLAY_REG_Q_HIGH:  qcfg[q_sel].high   <= mem_addr_t'(pwdata);
                `REPLAY_REG_Q_COUNT: qcfg[q_sel].count  <= count_t'(pwdata);
                default: ;
            endcase
        end
    end

endmodule

//--- rtl/replay_top.sv
`include "replay_config.svh"

module replay_top
    import replay_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        mem_req,
    output mem_addr_t   mem_addr,
    input  logic        mem_busy,
    input  mem_rsp_t    mem_rsp,
    output logic        out_valid,
    output entry_t      out_data,
    input  logic        out_ready
);

    queue_cfg_t  qcfg [`REPLAY_NUM_QUEUES];
    logic        start;
    logic        soft_rst;
    logic        busy;
    logic [31:0] sent_count;
    logic        fifo_wr;
    entry_t      fifo_din;
    level_t      level;
    logic        fifo_rd;
    entry_t      fifo_dout;
    logic        fifo_empty;

    // Software interface
    replay_regs i_replay_regs (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .qcfg, .start, .soft_rst, .busy, .sent_count
    );

    // Producer, scheduler and packer
    mem_to_fifo i_mem_to_fifo (
        .clk, .arst_n, .qcfg, .start, .soft_rst, .mem_req, .mem_addr,
        .mem_busy, .mem_rsp, .fifo_wr, .fifo_din, .level, .busy
    );

    replay_fifo i_replay_fifo (
        .clk, .arst_n, .soft_rst, .wr(fifo_wr), .din(fifo_din), .rd(fifo_rd),
        .dout(fifo_dout), .empty(fifo_empty), .level
    );

    // Consumer onto the output stream
    replay_tx i_replay_tx (
        .clk, .arst_n, .soft_rst, .start, .fifo_rd, .fifo_dout, .fifo_empty,
        .out_valid, .out_data, .out_ready, .sent_count
    );

endmodule

//--- rtl/replay_tx.sv
`include "replay_config.svh"

module replay_tx
    import replay_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        soft_rst,
    input  logic        start,
    output logic        fifo_rd,
    input  entry_t      fifo_dout,
    input  logic        fifo_empty,
    output logic        out_valid,
    output entry_t      out_data,
    input  logic        out_ready,
    output logic [31:0] sent_count
);

    logic xfer;
    logic load;

    assign xfer    = out_valid && out_ready;

    // Refill when the holding register is free or leaving this cycle
    assign load    = !fifo_empty && (!out_valid || out_ready);
    assign fifo_rd = load;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (soft_rst) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (xfer) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= fifo_dout;
        end
    end

    // Completed transfers since the last start
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sent_count <= '0;
        end else if (soft_rst || start) begin
            sent_count <= '0;
        end else if (xfer) begin
            sent_count <= sent_count + 1'b1;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module replay_tb -f vlog.f -o replay_sim \
    && ./obj_dir/replay_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"
exit 0

//--- vlog.f
+incdir+rtl
rtl/replay_pkg.sv
rtl/replay_regs.sv
rtl/mem_to_fifo.sv
rtl/replay_fifo.sv
rtl/replay_tx.sv
rtl/replay_top.sv
bench/replay_asserts.sv
bench/replay_tb.sv
